/* sim/trap_input.txt */
# instr taken branch_target ex_opcode jump_target mem_opcode mem_funct3 mem_address
# then expected trapped cause value, all fields hex
00000013 0 00000000 13 00000000 13 0 00000000 0 0 00000000
0000100f 0 00000000 13 00000000 13 0 00000000 1 1 00000000
00000073 0 00000000 13 00000000 13 0 00000000 1 2 00000000
00100073 0 00000000 13 00000000 13 0 00000000 1 3 00000000
30200073 0 00000000 13 00000000 13 0 00000000 1 4 00000000
10500073 0 00000000 13 00000000 13 0 00000000 0 0 00000000
0ff0000f 0 00000000 13 00000000 13 0 00000000 0 0 00000000
00000063 1 00001002 13 00000000 13 0 00000000 1 5 00001002
00000063 0 00001002 13 00000000 13 0 00000000 0 0 00000000
00000063 1 00001004 13 00000000 13 0 00000000 0 0 00000000
00000013 0 00000000 6f 00002003 13 0 00000000 1 5 00002003
00000013 0 00000000 67 00002002 13 0 00000000 1 5 00002002
00000013 0 00000000 6f 00002004 13 0 00000000 0 0 00000000
00000013 0 00000000 13 00000000 23 0 00003003 0 0 00000000
00000013 0 00000000 13 00000000 23 1 00003001 1 6 00003001
00000013 0 00000000 13 00000000 23 1 00003002 0 0 00000000
00000013 0 00000000 13 00000000 23 2 00003002 1 6 00003002
00000013 0 00000000 13 00000000 23 2 00003004 0 0 00000000
00000013 0 00000000 13 00000000 23 3 00003000 1 6 00003000
00000073 0 00000000 6f 00004001 23 2 00005002 1 6 00005002
00000073 0 00000000 6f 00004001 13 0 00000000 1 5 00004001
00000013 0 00000000 13 00000000 13 0 00000000 0 0 00000000

/* tb.f */
hdl/trap_pkg.sv
hdl/system_trap_decoder.sv
hdl/alignment_trap_detector.sv
hdl/trap_arbiter.sv
hdl/trap_unit.sv
sim/trap_unit_properties.sv
sim/trap_checker.sv
sim/tb_trap_unit.sv

/* run.sh */
#!/bin/sh
# build the trap unit testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_trap_unit \
	-f tb.f \
	-o tb_trap_unit

status=0
./obj_dir/tb_trap_unit > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Result: FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

/* sim/tb_trap_unit.sv */
`timescale 1ns/1ps

module tb_trap_unit;

	import trap_pkg::*;

	localparam string vector_file = "sim/trap_input.txt";
	localparam int extra_cycles = 20;	// margin over the vector count

	logic         clk;
	logic         reset;
	id_stage_s    id;
	ex_stage_s    ex;
	mem_stage_s   mem;
	trap_report_s trap;
	trap_report_s expected_next;	// belongs to the vector now on the inputs
	trap_report_s expected;		// lines up with trap
	logic         expected_valid_next;
	logic         expected_valid;
	int           vector_index_next;
	int           vector_index;
	int           mismatch_count;
	int           check_count;
	int           other_errors;
	int           cycle_count;
	int           cycle_limit;

	id_stage_s    id_vectors[$];
	ex_stage_s    ex_vectors[$];
	mem_stage_s   mem_vectors[$];
	trap_report_s exp_vectors[$];

	trap_unit #(
		.XLEN (xlen)
	) dut0 (
		.clk   (clk),
		.reset (reset),
		.id    (id),
		.ex    (ex),
		.mem   (mem),
		.trap  (trap)
	);

	trap_checker check0 (
		.clk            (clk),
		.reset          (reset),
		.valid          (expected_valid),
		.vector_index   (vector_index),
		.expected       (expected),
		.actual         (trap),
		.mismatch_count (mismatch_count),
		.check_count    (check_count)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// one cycle of delay, same as the arbiter register
	always @(posedge clk) begin
		if (reset) begin
			expected_valid <= 1'b0;
		end
		else begin
			expected_valid <= expected_valid_next;
		end
		expected <= expected_next;
		vector_index <= vector_index_next;
	end

	always @(posedge clk) begin
		if (reset) begin
			cycle_count <= 0;
		end
		else if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$finish;
		end
		else begin
			cycle_count <= cycle_count + 1;
		end
	end

	task automatic read_vectors();
		int           fd;
		int           fields;
		string        line;
		logic [31:0]  instr;
		logic         taken;
		logic [31:0]  branch_target;
		logic [6:0]   ex_opcode;
		logic [31:0]  jump_target;
		logic [6:0]   mem_opcode;
		logic [2:0]   mem_funct3;
		logic [31:0]  mem_address;
		logic         exp_trapped;
		logic [2:0]   exp_cause;
		logic [31:0]  exp_value;
		id_stage_s    id_v;
		ex_stage_s    ex_v;
		mem_stage_s   mem_v;
		trap_report_s exp_v;
		fd = $fopen(vector_file, "r");
		if (fd == 0) begin
			$display("could not open vector file %s", vector_file);
			other_errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 2 || line.substr(0, 0) == "#") begin
				continue;	// header or blank line
			end
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", instr, taken,
				branch_target, ex_opcode, jump_target, mem_opcode, mem_funct3,
				mem_address, exp_trapped, exp_cause, exp_value);
			if (fields != 11) begin
				$display("malformed line in vector file: %s", line);
				other_errors++;
				continue;
			end
			id_v.instr = instr;
			id_v.branch_predicted_taken = taken;
			id_v.branch_target = branch_target;
			ex_v.ex_opcode = ex_opcode;
			ex_v.jump_target = jump_target;
			mem_v.mem_opcode = mem_opcode;
			mem_v.mem_funct3 = mem_funct3;
			mem_v.mem_address = mem_address;
			exp_v.trapped = exp_trapped;
			exp_v.cause = trap_cause_e'(exp_cause);
			exp_v.value = exp_value;
			id_vectors.push_back(id_v);
			ex_vectors.push_back(ex_v);
			mem_vectors.push_back(mem_v);
			exp_vectors.push_back(exp_v);
		end
		$fclose(fd);
	endtask

	initial begin
		reset = 1'b1;
		id = '0;
		id.instr = 32'h0000_0073;	// ECALL held while reset is high
		ex = '0;
		mem = '0;
		expected_next = no_trap;
		expected_valid_next = 1'b0;
		vector_index_next = 0;
		other_errors = 0;
		read_vectors();
		cycle_limit = id_vectors.size() + extra_cycles;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		id <= '0;	// opcode 0 matches nothing
		foreach (id_vectors[i]) begin
			@(posedge clk);
			id <= id_vectors[i];
			ex <= ex_vectors[i];
			mem <= mem_vectors[i];
			expected_next <= exp_vectors[i];
			expected_valid_next <= 1'b1;
			vector_index_next <= i;
		end
		@(posedge clk);
		id <= '0;
		ex <= '0;
		mem <= '0;
		expected_valid_next <= 1'b0;
		@(posedge clk);
		@(negedge clk);	// last compare is done
		if (check_count != id_vectors.size() || id_vectors.size() == 0) begin
			$display("checked %0d results for %0d vectors", check_count, id_vectors.size());
			other_errors++;
		end
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("Result: PASSED");
		end
		else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* sim/trap_checker.sv */
`timescale 1ns/1ps

module trap_checker (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   valid,
	input  int                     vector_index,
	input  trap_pkg::trap_report_s expected,
	input  trap_pkg::trap_report_s actual,
	output int                     mismatch_count,
	output int                     check_count
);

	import trap_pkg::*;

	// falling edge, away from the register update
	always @(negedge clk) begin
		if (reset) begin
			mismatch_count <= 0;
			check_count <= 0;
		end
		else if (valid) begin
			check_count <= check_count + 1;
			if (actual !== expected) begin
				mismatch_count <= mismatch_count + 1;
				$write("MISMATCH vector_%0d: expected trapped=%0b cause=%0d value=%h",
					vector_index, expected.trapped, expected.cause, expected.value);
				$display(", actual trapped=%0b cause=%0d value=%h",
					actual.trapped, actual.cause, actual.value);
			end
		end
	end

endmodule

/* sim/trap_unit_properties.sv */
`timescale 1ns/1ps

module trap_unit_properties (
	input logic                   clk,
	input logic                   reset,
	input trap_pkg::trap_report_s trap
);

	import trap_pkg::*;

	reset_clears_trap: assert property (@(posedge clk) reset |=> !trap.trapped)
		else $error("trap still raised one cycle after reset");

	// a cleared report carries nothing
	idle_report_clean: assert property (@(posedge clk)
		!trap.trapped |-> (trap.cause == NONE && trap.value == '0))
		else $error("cleared trap carries a cause or a value");

	raised_trap_has_cause: assert property (@(posedge clk) trap.trapped |-> trap.cause != NONE)
		else $error("trap raised with cause NONE");

endmodule

bind trap_arbiter trap_unit_properties props0 (
	.clk   (clk),
	.reset (reset),
	.trap  (trap)
);

/* hdl/trap_unit.sv */
`timescale 1ns/1ps

module trap_unit #(
	parameter int XLEN = trap_pkg::xlen
) (
	input  logic                   clk,
	input  logic                   reset,
	input  trap_pkg::id_stage_s    id,
	input  trap_pkg::ex_stage_s    ex,
	input  trap_pkg::mem_stage_s   mem,
	output trap_pkg::trap_report_s trap
);

	import trap_pkg::*;

	trap_report_s decode_report;	// FENCE.I, ECALL, EBREAK, MRET
	trap_report_s ex_mem_report;	// jump or store misalignment
	trap_report_s id_branch_report;	// predicted branch misalignment

	system_trap_decoder decoder0 (
		.instr  (id.instr),
		.report (decode_report)
	);

	alignment_trap_detector #(
		.XLEN (XLEN)
	) align0 (
		.id               (id),
		.ex               (ex),
		.mem              (mem),
		.ex_mem_report    (ex_mem_report),
		.id_branch_report (id_branch_report)
	);

	trap_arbiter #(
		.XLEN (XLEN)
	) arbiter0 (
		.clk              (clk),
		.reset            (reset),
		.decode_report    (decode_report),
		.ex_mem_report    (ex_mem_report),
		.id_branch_report (id_branch_report),
		.trap             (trap)
	);

endmodule

/* hdl/trap_arbiter.sv */
`timescale 1ns/1ps

module trap_arbiter #(
	parameter int XLEN = trap_pkg::xlen
) (
	input  logic                   clk,
	input  logic                   reset,
	input  trap_pkg::trap_report_s decode_report,
	input  trap_pkg::trap_report_s ex_mem_report,
	input  trap_pkg::trap_report_s id_branch_report,
	output trap_pkg::trap_report_s trap
);

	import trap_pkg::*;

	if (XLEN != xlen) begin : g_xlen_check
		$error("trap_arbiter: XLEN %0d differs from package width %0d", XLEN, xlen);
	end

	trap_report_s next_trap;	// winner of this cycle
	logic [1:0]   winner;		// which report was taken, 0 when none

	// oldest stage first; ID system ops and ID branches never overlap
	always_comb begin
		if (ex_mem_report.trapped) begin
			winner = 2'd1;
		end
		else if (decode_report.trapped) begin
			winner = 2'd2;
		end
		else if (id_branch_report.trapped) begin
			winner = 2'd3;
		end
		else begin
			winner = 2'd0;
		end
	end

	always_comb begin
		case (winner)
			2'd1:    next_trap = ex_mem_report;
			2'd2:    next_trap = decode_report;
			2'd3:    next_trap = id_branch_report;
			default: next_trap = no_trap;
		endcase
	end

	// single pipeline register of the unit
	always_ff @(posedge clk) begin
		if (reset) begin
			trap <= no_trap;
		end
		else begin
			trap <= next_trap;
		end
	end

endmodule

/* hdl/alignment_trap_detector.sv */
`timescale 1ns/1ps

module alignment_trap_detector #(
	parameter int XLEN = trap_pkg::xlen
) (
	input  trap_pkg::id_stage_s    id,
	input  trap_pkg::ex_stage_s    ex,
	input  trap_pkg::mem_stage_s   mem,
	output trap_pkg::trap_report_s ex_mem_report,
	output trap_pkg::trap_report_s id_branch_report
);

	import trap_pkg::*;

	if (XLEN != xlen) begin : g_xlen_check
		$error("alignment_trap_detector: XLEN %0d differs from package width %0d",
			XLEN, xlen);
	end

	logic            branch_taken;	// predicted-taken branch in ID
	logic            ex_is_jump;
	logic            mem_is_store;
	logic            store_misaligned;
	logic [XLEN-1:0] branch_target;
	logic [XLEN-1:0] jump_target;
	logic [XLEN-1:0] store_address;

	assign branch_taken = (id.instr.system.opcode == BRANCH) && id.branch_predicted_taken;
	assign ex_is_jump = (ex.ex_opcode == JAL) || (ex.ex_opcode == JALR);
	assign mem_is_store = (mem.mem_opcode == STORE);

	assign branch_target = id.branch_target;
	assign jump_target = ex.jump_target;
	assign store_address = mem.mem_address;

	// size rule for stores
	always_comb begin
		case (mem.mem_funct3)
			store_byte: store_misaligned = 1'b0;
			store_half: store_misaligned = store_address[0];
			store_word: store_misaligned = |store_address[1:0];
			default:    store_misaligned = 1'b1;	// no wider stores on RV32I
		endcase
	end

	// MEM is older than EX, so it is reported first
	always_comb begin
		ex_mem_report = no_trap;
		if (mem_is_store && store_misaligned) begin
			ex_mem_report.trapped = 1'b1;
			ex_mem_report.cause = MISALIGNED_MEMORY;
			ex_mem_report.value = store_address;
		end
		else if (ex_is_jump && |jump_target[1:0]) begin
			ex_mem_report.trapped = 1'b1;
			ex_mem_report.cause = MISALIGNED_INSTRUCTION;
			ex_mem_report.value = jump_target;
		end
	end

	always_comb begin
		id_branch_report = no_trap;
		if (branch_taken && |branch_target[1:0]) begin	// no C extension
			id_branch_report.trapped = 1'b1;
			id_branch_report.cause = MISALIGNED_INSTRUCTION;
			id_branch_report.value = branch_target;
		end
	end

endmodule

/* hdl/system_trap_decoder.sv */
`timescale 1ns/1ps

module system_trap_decoder (
	input  trap_pkg::instr_word_u  instr,
	output trap_pkg::trap_report_s report
);

	import trap_pkg::*;

	logic is_fence_i;	// FENCE with funct3 001
	logic is_priv;		// SYSTEM with funct3 000

	// fence view for Zifencei
	assign is_fence_i = (instr.fence.opcode == FENCE) &&
		(instr.fence.funct3 == funct3_fence_i);

	// system view for the privileged group
	assign is_priv = (instr.system.opcode == SYSTEM) &&
		(instr.system.funct3 == funct3_priv);

	always_comb begin
		report = no_trap;	// value stays zero for all of these
		if (is_fence_i) begin
			report.trapped = 1'b1;
			report.cause = FENCE_I;
		end
		else if (is_priv) begin
			case (instr.system.funct12)
				funct12_mret: begin
					report.trapped = 1'b1;
					report.cause = MRET;
				end
				funct12_ebreak: begin
					report.trapped = 1'b1;
					report.cause = EBREAK;
				end
				funct12_ecall: begin
					report.trapped = 1'b1;
					report.cause = ECALL;
				end
				default: begin
					// wfi, sret and friends are not handled here
					report = no_trap;
				end
			endcase
		end
	end

endmodule

/* hdl/trap_pkg.sv */
package trap_pkg;

	localparam int xlen = 32;	// address width the structs are built for

	// major opcodes the trap unit has to recognise
	typedef enum logic [6:0] {
		FENCE  = 7'b0001111,	// MISC-MEM
		SYSTEM = 7'b1110011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [2:0] {
		NONE                   = 3'd0,
		FENCE_I                = 3'd1,
		ECALL                  = 3'd2,
		EBREAK                 = 3'd3,
		MRET                   = 3'd4,
		MISALIGNED_INSTRUCTION = 3'd5,
		MISALIGNED_MEMORY      = 3'd6
	} trap_cause_e;

	localparam logic [2:0]  funct3_fence_i = 3'b001;	// Zifencei
	localparam logic [2:0]  funct3_priv    = 3'b000;	// ECALL/EBREAK/MRET group
	localparam logic [11:0] funct12_ecall  = 12'h000;
	localparam logic [11:0] funct12_ebreak = 12'h001;
	localparam logic [11:0] funct12_mret   = 12'h302;

	// store access sizes in funct3
	localparam logic [2:0] store_byte = 3'b000;
	localparam logic [2:0] store_half = 3'b001;
	localparam logic [2:0] store_word = 3'b010;

	typedef struct packed {
		logic [11:0] funct12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} system_fmt_s;

	typedef struct packed {
		logic [3:0] fm;		// fence mode
		logic [3:0] pred;
		logic [3:0] succ;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} fence_fmt_s;

	// one ID word, read either as SYSTEM or as MISC-MEM
	typedef union packed {
		system_fmt_s system;
		fence_fmt_s  fence;
	} instr_word_u;

	typedef struct packed {
		instr_word_u       instr;
		logic              branch_predicted_taken;
		logic [xlen-1:0]   branch_target;
	} id_stage_s;

	typedef struct packed {
		logic [6:0]      ex_opcode;
		logic [xlen-1:0] jump_target;
	} ex_stage_s;

	typedef struct packed {
		logic [6:0]      mem_opcode;
		logic [2:0]      mem_funct3;	// access size
		logic [xlen-1:0] mem_address;
	} mem_stage_s;

	typedef struct packed {
		logic            trapped;
		trap_cause_e     cause;
		logic [xlen-1:0] value;		// faulting target or address
	} trap_report_s;

	localparam trap_report_s no_trap = '{trapped: 1'b0, cause: NONE, value: '0};

endpackage
